// File: design/exu_pkg.sv
`default_nettype none

package exu_pkg;

  // One instruction word seen through each RV32I format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } instr_t;

  typedef struct packed {
    logic [31:0] pc;
    instr_t      instr;
  } fetch_t;

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
  } alu_op_e;

  typedef enum logic {op1_rs1, op1_pc} op1_sel_e;
  typedef enum logic {op2_rs2, op2_imm} op2_sel_e;
  typedef enum logic [1:0] {npc_seq, npc_jal, npc_jalr, npc_branch} npc_sel_e;
  typedef enum logic [1:0] {wb_alu, wb_link, wb_imm} wb_sel_e;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    alu_op_e     alu_op;
    op1_sel_e    op1_sel;
    op2_sel_e    op2_sel;
    npc_sel_e    npc_sel;
    wb_sel_e     wb_sel;
    logic        writes_rd;
  } uop_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        writes_rd;
    logic [31:0] wdata;
    logic [31:0] next_pc;
    logic        redirect; // next_pc is not pc+4
  } retire_t;

endpackage

`default_nettype wire

// File: design/exu_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module exu_regfile (
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire logic [4:0]  read_index_a,
  input  wire logic [4:0]  read_index_b,
  input  wire logic        write_enable,
  input  wire logic [4:0]  write_index,
  input  wire logic [31:0] write_data,
  output logic      [31:0] read_data_a,
  output logic      [31:0] read_data_b
);

  logic [31:0] regs [31:1]; // x0 has no storage

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && write_index != 5'd0) begin
      regs[write_index] <= write_data;
    end
  end

  // Reads give the pre-write value and execute forwards the pending record
  assign read_data_a = (read_index_a == 5'd0) ? 32'd0 : regs[read_index_a];
  assign read_data_b = (read_index_b == 5'd0) ? 32'd0 : regs[read_index_b];

endmodule

`default_nettype wire

// File: design/exu_alu.sv
`timescale 1ns/1ns
`default_nettype none

module exu_alu (
  input  exu_pkg::alu_op_e op,
  input  wire logic [31:0] operand_a,
  input  wire logic [31:0] operand_b,
  output logic      [31:0] result
);

  logic [4:0] shamt;

  assign shamt = operand_b[4:0];

  always_comb begin
    result = '0;
    unique case (op)
      exu_pkg::alu_add:  result = operand_a + operand_b;
      exu_pkg::alu_sub:  result = operand_a - operand_b;
      exu_pkg::alu_sll:  result = operand_a << shamt;
      exu_pkg::alu_slt:  result = {31'd0, $signed(operand_a) < $signed(operand_b)};
      exu_pkg::alu_sltu: result = {31'd0, operand_a < operand_b};
      exu_pkg::alu_xor:  result = operand_a ^ operand_b;
      exu_pkg::alu_srl:  result = operand_a >> shamt;
      exu_pkg::alu_sra:  result = $unsigned($signed(operand_a) >>> shamt);
      exu_pkg::alu_or:   result = operand_a | operand_b;
      exu_pkg::alu_and:  result = operand_a & operand_b;
      // Branch compares return the outcome in bit 0
      exu_pkg::alu_eq:   result = {31'd0, operand_a == operand_b};
      exu_pkg::alu_ne:   result = {31'd0, operand_a != operand_b};
      exu_pkg::alu_lt:   result = {31'd0, $signed(operand_a) < $signed(operand_b)};
      exu_pkg::alu_ge:   result = {31'd0, $signed(operand_a) >= $signed(operand_b)};
      exu_pkg::alu_ltu:  result = {31'd0, operand_a < operand_b};
      exu_pkg::alu_geu:  result = {31'd0, operand_a >= operand_b};
    endcase
  end

endmodule

`default_nettype wire

// File: design/exu_decode.sv
`timescale 1ns/1ns
`default_nettype none

module exu_decode (
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire logic       in_valid,
  input  exu_pkg::fetch_t in_data,
  output logic            in_ready,
  output logic            uop_valid,
  output exu_pkg::uop_t   uop,
  input  wire logic       uop_ready
);

  exu_pkg::instr_t instr;
  exu_pkg::uop_t   dec;

  // funct3 to ALU op for OP and OP-IMM
  function automatic exu_pkg::alu_op_e arith_op(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  arith_op = alt ? exu_pkg::alu_sub : exu_pkg::alu_add;
      3'b001:  arith_op = exu_pkg::alu_sll;
      3'b010:  arith_op = exu_pkg::alu_slt;
      3'b011:  arith_op = exu_pkg::alu_sltu;
      3'b100:  arith_op = exu_pkg::alu_xor;
      3'b101:  arith_op = alt ? exu_pkg::alu_sra : exu_pkg::alu_srl;
      3'b110:  arith_op = exu_pkg::alu_or;
      default: arith_op = exu_pkg::alu_and;
    endcase
  endfunction

  function automatic exu_pkg::alu_op_e branch_op(input logic [2:0] funct3);
    case (funct3)
      3'b001:  branch_op = exu_pkg::alu_ne;
      3'b100:  branch_op = exu_pkg::alu_lt;
      3'b101:  branch_op = exu_pkg::alu_ge;
      3'b110:  branch_op = exu_pkg::alu_ltu;
      3'b111:  branch_op = exu_pkg::alu_geu;
      default: branch_op = exu_pkg::alu_eq;
    endcase
  endfunction

  assign instr = in_data.instr;

  always_comb begin
    dec           = '0; // No-op unless recognized
    dec.pc        = in_data.pc;
    dec.rs1       = instr.r_fmt.rs1;
    dec.rs2       = instr.r_fmt.rs2;
    dec.rd        = instr.r_fmt.rd;
    dec.alu_op    = exu_pkg::alu_add;
    dec.op1_sel   = exu_pkg::op1_rs1;
    dec.op2_sel   = exu_pkg::op2_rs2;
    dec.npc_sel   = exu_pkg::npc_seq;
    dec.wb_sel    = exu_pkg::wb_alu;
    case (instr.r_fmt.opcode)
      exu_pkg::opc_op: begin
        dec.alu_op    = arith_op(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
        dec.writes_rd = 1'b1;
      end
      exu_pkg::opc_op_imm: begin
        dec.imm       = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
        dec.alu_op    = arith_op(instr.i_fmt.funct3,
                                 instr.i_fmt.funct3 == 3'b101 && instr.r_fmt.funct7[5]);
        dec.op2_sel   = exu_pkg::op2_imm;
        dec.writes_rd = 1'b1;
      end
      exu_pkg::opc_lui: begin
        dec.imm       = {instr.u_fmt.imm, 12'd0};
        dec.wb_sel    = exu_pkg::wb_imm;
        dec.writes_rd = 1'b1;
      end
      exu_pkg::opc_auipc: begin
        dec.imm       = {instr.u_fmt.imm, 12'd0};
        dec.op1_sel   = exu_pkg::op1_pc;
        dec.op2_sel   = exu_pkg::op2_imm;
        dec.writes_rd = 1'b1;
      end
      exu_pkg::opc_jal: begin
        dec.imm       = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                         instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
        dec.npc_sel   = exu_pkg::npc_jal;
        dec.wb_sel    = exu_pkg::wb_link;
        dec.writes_rd = 1'b1;
      end
      exu_pkg::opc_jalr: begin
        dec.imm       = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
        dec.op2_sel   = exu_pkg::op2_imm;
        dec.npc_sel   = exu_pkg::npc_jalr;
        dec.wb_sel    = exu_pkg::wb_link;
        dec.writes_rd = 1'b1;
      end
      exu_pkg::opc_branch: begin
        if (instr.b_fmt.funct3[2:1] != 2'b01) begin // 010 and 011 are not branches
          dec.imm     = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                         instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
          dec.alu_op  = branch_op(instr.b_fmt.funct3);
          dec.npc_sel = exu_pkg::npc_branch;
        end
      end
      default: ;
    endcase
    if (dec.rd == 5'd0) begin
      dec.writes_rd = 1'b0;
    end
  end

  assign in_ready = !uop_valid || uop_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      uop_valid <= 1'b0;
    end else if (in_ready) begin
      uop_valid <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      uop <= dec;
    end
  end

endmodule

`default_nettype wire

// File: design/exu_execute.sv
`timescale 1ns/1ns
`default_nettype none

module exu_execute #(
  parameter logic [31:0] reset_pc = 32'h0
) (
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire logic        uop_valid,
  input  exu_pkg::uop_t    uop,
  output logic             uop_ready,
  output logic             out_valid,
  output exu_pkg::retire_t out_data,
  input  wire logic        out_ready,
  output logic      [4:0]  rf_read_index_a,
  output logic      [4:0]  rf_read_index_b,
  input  wire logic [31:0] rf_read_data_a,
  input  wire logic [31:0] rf_read_data_b,
  output logic             rf_write_enable,
  output logic      [4:0]  rf_write_index,
  output logic      [31:0] rf_write_data,
  output exu_pkg::alu_op_e alu_op,
  output logic      [31:0] alu_operand_a,
  output logic      [31:0] alu_operand_b,
  input  wire logic [31:0] alu_result
);

  logic [31:0]      expected_pc;
  logic [31:0]      rs1_value;
  logic [31:0]      rs2_value;
  logic [31:0]      seq_pc;
  logic [31:0]      target_pc;
  logic             take;
  logic             on_path;
  exu_pkg::retire_t ret;

  assign rf_read_index_a = uop.rs1;
  assign rf_read_index_b = uop.rs2;

  // writes_rd is never set for x0, so a match is always a real register
  assign rs1_value = (out_valid && out_data.writes_rd && out_data.rd == uop.rs1) ?
                     out_data.wdata : rf_read_data_a;
  assign rs2_value = (out_valid && out_data.writes_rd && out_data.rd == uop.rs2) ?
                     out_data.wdata : rf_read_data_b;

  assign alu_op        = uop.alu_op;
  assign alu_operand_a = (uop.op1_sel == exu_pkg::op1_pc) ? uop.pc : rs1_value;
  assign alu_operand_b = (uop.op2_sel == exu_pkg::op2_imm) ? uop.imm : rs2_value;

  assign seq_pc    = uop.pc + 32'd4;
  assign target_pc = uop.pc + uop.imm;

  always_comb begin
    ret           = '0;
    ret.pc        = uop.pc;
    ret.rd        = uop.rd;
    ret.writes_rd = uop.writes_rd;
    case (uop.npc_sel)
      exu_pkg::npc_jal:    ret.next_pc = target_pc;
      exu_pkg::npc_jalr:   ret.next_pc = {alu_result[31:1], 1'b0};
      exu_pkg::npc_branch: ret.next_pc = alu_result[0] ? target_pc : seq_pc;
      default:             ret.next_pc = seq_pc;
    endcase
    case (uop.wb_sel)
      exu_pkg::wb_link: ret.wdata = seq_pc;
      exu_pkg::wb_imm:  ret.wdata = uop.imm; // LUI
      default:          ret.wdata = alu_result;
    endcase
    ret.redirect = ret.next_pc != seq_pc;
  end

  assign uop_ready = !out_valid || out_ready;
  assign take      = uop_valid && uop_ready;
  assign on_path   = uop.pc == expected_pc; // Anything else is fetched past a redirect

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid   <= 1'b0;
      expected_pc <= reset_pc;
    end else begin
      if (uop_ready) begin
        out_valid <= take && on_path;
      end
      if (take && on_path) begin
        expected_pc <= ret.next_pc;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (take && on_path) begin
      out_data <= ret;
    end
  end

  // Architectural write when the record leaves
  assign rf_write_enable = out_valid && out_ready && out_data.writes_rd;
  assign rf_write_index  = out_data.rd;
  assign rf_write_data   = out_data.wdata;

endmodule

`default_nettype wire

// File: design/exu_core.sv
`timescale 1ns/1ns
`default_nettype none

module exu_core #(
  parameter logic [31:0] reset_pc = 32'h0
) (
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire logic        in_valid,
  input  exu_pkg::fetch_t  in_data,
  output logic             in_ready,
  output logic             out_valid,
  output exu_pkg::retire_t out_data,
  input  wire logic        out_ready
);

  logic             uop_valid;
  logic             uop_ready;
  exu_pkg::uop_t    uop;
  logic [4:0]       rf_read_index_a;
  logic [4:0]       rf_read_index_b;
  logic [31:0]      rf_read_data_a;
  logic [31:0]      rf_read_data_b;
  logic             rf_write_enable;
  logic [4:0]       rf_write_index;
  logic [31:0]      rf_write_data;
  exu_pkg::alu_op_e alu_op;
  logic [31:0]      alu_operand_a;
  logic [31:0]      alu_operand_b;
  logic [31:0]      alu_result;

  exu_decode u_decode (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .uop_valid (uop_valid),
    .uop       (uop),
    .uop_ready (uop_ready)
  );

  exu_regfile u_regfile (
    .clock        (clock),
    .reset        (reset),
    .read_index_a (rf_read_index_a),
    .read_index_b (rf_read_index_b),
    .write_enable (rf_write_enable),
    .write_index  (rf_write_index),
    .write_data   (rf_write_data),
    .read_data_a  (rf_read_data_a),
    .read_data_b  (rf_read_data_b)
  );

  exu_alu u_alu (
    .op        (alu_op),
    .operand_a (alu_operand_a),
    .operand_b (alu_operand_b),
    .result    (alu_result)
  );

  exu_execute #(
    .reset_pc (reset_pc)
  ) u_execute (
    .clock           (clock),
    .reset           (reset),
    .uop_valid       (uop_valid),
    .uop             (uop),
    .uop_ready       (uop_ready),
    .out_valid       (out_valid),
    .out_data        (out_data),
    .out_ready       (out_ready),
    .rf_read_index_a (rf_read_index_a),
    .rf_read_index_b (rf_read_index_b),
    .rf_read_data_a  (rf_read_data_a),
    .rf_read_data_b  (rf_read_data_b),
    .rf_write_enable (rf_write_enable),
    .rf_write_index  (rf_write_index),
    .rf_write_data   (rf_write_data),
    .alu_op          (alu_op),
    .alu_operand_a   (alu_operand_a),
    .alu_operand_b   (alu_operand_b),
    .alu_result      (alu_result)
  );

endmodule

`default_nettype wire

// File: tb/exu_core_properties.sv
`timescale 1ns/1ns
`default_nettype none

module exu_core_properties (
  input wire logic        clock,
  input wire logic        reset,
  input wire logic        in_valid,
  input wire logic        in_ready,
  input exu_pkg::fetch_t  in_data,
  input wire logic        out_valid,
  input wire logic        out_ready,
  input exu_pkg::retire_t out_data
);

  // Fetch side must hold a stalled instruction
  in_held: assert property (@(posedge clock) disable iff (reset)
    in_valid && !in_ready |=> in_valid && $stable(in_data));

  out_held: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

  out_idle_in_reset: assert property (@(posedge clock) reset |=> !out_valid);

endmodule

bind exu_core exu_core_properties u_properties (
  .clock     (clock),
  .reset     (reset),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .in_data   (in_data),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data)
);

`default_nettype wire

// File: tb/exu_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module exu_core_tb;

  localparam int num_instr  = 2000;
  localparam int wait_limit = 200;

  logic             clock;
  logic             reset;
  logic             in_valid;
  exu_pkg::fetch_t  in_data;
  logic             in_ready;
  logic             out_valid;
  exu_pkg::retire_t out_data;
  logic             out_ready;

  logic [31:0]      lfsr_state = 32'h52fc;
  logic [31:0]      model_regs [0:31];
  logic [31:0]      model_pc = 32'h0;
  logic [31:0]      wrong_pc;
  int               wrong_left = 0;
  exu_pkg::retire_t expected_q [$];
  exu_pkg::retire_t exp_rec;
  logic             in_taken;
  logic             timed_out = 1'b0;
  int               errors = 0;
  int               checks = 0;
  int               retired = 0;
  int               dropped = 0;

  exu_core #(.reset_pc(32'h0)) u_exu_core (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  // RV32I OP and OP-IMM semantics
  function automatic logic [31:0] arith_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  // Random instruction at pc, run through the model when it is on the path
  task automatic build_instr(input logic [31:0] pc, output logic [31:0] word);
    logic [3:0]       kind;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [2:0]       f3;
    logic             alt;
    logic [11:0]      imm12;
    logic [19:0]      imm20;
    logic [31:0]      boff;
    logic [31:0]      joff;
    logic [6:0]       opc;
    exu_pkg::retire_t rec;
    kind  = 4'(rand_bits(4));
    rd    = 5'(rand_bits(3)); // x0..x7 keeps dependencies dense
    rs1   = 5'(rand_bits(3));
    rs2   = 5'(rand_bits(3));
    f3    = 3'(rand_bits(3));
    alt   = 1'(rand_bits(1));
    imm12 = 12'(rand_bits(12));
    imm20 = 20'(rand_bits(20));
    boff  = {{19{imm12[11]}}, imm12, 1'b0};
    joff  = {{11{imm20[19]}}, imm20, 1'b0};
    rec           = '0;
    rec.pc        = pc;
    rec.rd        = rd;
    rec.writes_rd = rd != 5'd0;
    rec.next_pc   = pc + 32'd4;
    if (kind < 4'd5) begin
      alt       = alt && (f3 == 3'd0 || f3 == 3'd5);
      word      = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
      rec.wdata = arith_result(f3, alt, model_regs[rs1], model_regs[rs2]);
    end else if (kind < 4'd8) begin
      alt = alt && f3 == 3'd5;
      if (f3 == 3'd1 || f3 == 3'd5) imm12 = {1'b0, alt, 5'd0, imm12[4:0]};
      word      = {imm12, rs1, f3, rd, 7'b0010011};
      rec.wdata = arith_result(f3, alt, model_regs[rs1], {{20{imm12[11]}}, imm12});
    end else if (kind == 4'd8) begin
      word      = {imm20, rd, 7'b0110111};
      rec.wdata = {imm20, 12'd0};
    end else if (kind == 4'd9) begin
      word      = {imm20, rd, 7'b0010111};
      rec.wdata = pc + {imm20, 12'd0};
    end else if (kind == 4'd10) begin
      word        = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
      rec.wdata   = pc + 32'd4;
      rec.next_pc = pc + joff;
    end else if (kind == 4'd11) begin
      word        = {imm12, rs1, 3'b000, rd, 7'b1100111};
      rec.wdata   = pc + 32'd4;
      rec.next_pc = (model_regs[rs1] + {{20{imm12[11]}}, imm12}) & ~32'd1;
    end else if (kind < 4'd15) begin
      if (f3[2:1] == 2'b01) f3 = {2'b00, f3[0]}; // Only the six real branches
      word          = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
      rec.writes_rd = 1'b0;
      if (branch_taken(f3, model_regs[rs1], model_regs[rs2])) rec.next_pc = pc + boff;
    end else begin
      case (rand_bits(2))
        32'd0:   opc = 7'b0000011;
        32'd1:   opc = 7'b0100011;
        32'd2:   opc = 7'b1110011;
        default: opc = 7'b0001111;
      endcase
      word          = {imm20, rd, opc};
      rec.writes_rd = 1'b0;
    end
    rec.redirect = rec.next_pc != pc + 32'd4;
    if (pc == model_pc) begin
      if (rec.writes_rd) model_regs[rd] = rec.wdata;
      model_pc   = rec.next_pc;
      wrong_left = 0;
      expected_q.push_back(rec);
      if (rec.redirect && rand_bits(1) != 0) begin
        wrong_left = int'(rand_bits(2) % 3) + 1; // Sequential fetch past the jump
        wrong_pc   = pc + 32'd4;
      end
    end else begin
      dropped++;
    end
  endtask

  // Sample the input handshake mid-cycle, then move to the next rising edge
  task automatic next_edge();
    @(negedge clock);
    in_taken = in_valid && in_ready;
    @(posedge clock);
    out_ready <= rand_bits(2) != 0;
  endtask

  always @(negedge clock) begin
    if (!reset && out_valid && out_ready) begin
      if (expected_q.size() == 0) begin
        $display("ERROR at %0t: unexpected retire record for pc %h", $time, out_data.pc);
        errors++;
      end else begin
        exp_rec = expected_q.pop_front();
        check_value("out_data.pc", out_data.pc, exp_rec.pc);
        check_value("out_data.writes_rd", 32'(out_data.writes_rd), 32'(exp_rec.writes_rd));
        if (exp_rec.writes_rd) begin
          check_value("out_data.rd", 32'(out_data.rd), 32'(exp_rec.rd));
          check_value("out_data.wdata", out_data.wdata, exp_rec.wdata);
        end
        check_value("out_data.next_pc", out_data.next_pc, exp_rec.next_pc);
        check_value("out_data.redirect", 32'(out_data.redirect), 32'(exp_rec.redirect));
        retired++;
      end
    end
  end

  initial begin
    int          gap;
    int          waited;
    logic [31:0] pc;
    logic [31:0] word;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    for (int n = 0; n < num_instr && !timed_out; n++) begin
      gap = (rand_bits(2) == 0) ? int'(rand_bits(2)) : 0;
      if (gap != 0) begin
        in_valid <= 1'b0;
        repeat (gap) next_edge();
      end
      if (wrong_left > 0) begin
        pc         = wrong_pc;
        wrong_pc   = wrong_pc + 32'd4;
        wrong_left = wrong_left - 1;
      end else begin
        pc = model_pc;
      end
      build_instr(pc, word);
      in_valid <= 1'b1;
      in_data  <= {pc, word};
      in_taken = 1'b0;
      waited   = 0;
      while (!in_taken && waited < wait_limit) begin
        next_edge();
        waited++;
      end
      if (!in_taken) begin
        $display("ERROR at %0t: instruction at pc %h was never accepted", $time, pc);
        errors++;
        timed_out = 1'b1;
      end
    end
    in_valid <= 1'b0;
    waited = 0;
    while (!timed_out && expected_q.size() != 0 && waited < wait_limit) begin
      next_edge();
      waited++;
    end
    if (expected_q.size() != 0) begin
      $display("ERROR at %0t: %0d expected retire records never arrived", $time,
               expected_q.size());
      errors++;
    end
    repeat (4) next_edge(); // Room for a stray extra record
    $display("retired %0d, dropped %0d, checks %0d, errors %0d", retired, dropped, checks,
             errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
design/exu_pkg.sv
design/exu_regfile.sv
design/exu_alu.sv
design/exu_decode.sv
design/exu_execute.sv
design/exu_core.sv
tb/exu_core_properties.sv
tb/exu_core_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := exu_core_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard design/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(BUILD_DIR)
